// File: common/matmul_tile_pkg.sv
// Shared widths, register map and engine states of the matmul tile, imported by RTL and testbench
package matmul_tile_pkg;

  // Memory side
  typedef logic [31:0] addr_t;        // Word address
  typedef logic [31:0] data_t;        // Memory word

  // Arithmetic
  typedef logic signed [15:0] elem_t; // A/B element, low half of a word
  typedef logic signed [31:0] acc_t;  // Accumulator and C element

  // Configuration
  typedef logic [7:0] dim_t;          // M, N or K, 1 to 255
  typedef logic [2:0] reg_addr_t;     // Register index on the host port

  // Register offsets
  localparam reg_addr_t REG_CTRL   = 3'd0; // W: bit 0 starts the engine
  localparam reg_addr_t REG_STATUS = 3'd1; // R: busy, sticky done; W: clears done
  localparam reg_addr_t REG_A_BASE = 3'd2;
  localparam reg_addr_t REG_B_BASE = 3'd3;
  localparam reg_addr_t REG_C_BASE = 3'd4;
  localparam reg_addr_t REG_DIMS   = 3'd5; // M [7:0], N [15:8], K [23:16]

  // Bit positions inside CTRL and STATUS
  localparam int unsigned CTRL_START_BIT  = 0;
  localparam int unsigned STATUS_BUSY_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

  // Cycles from mac_valid until the product sits in the accumulator
  localparam int unsigned MAC_LAT = 2;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE,     // Waiting for start
    ISSUE_A,  // Presenting the A read
    ISSUE_B,  // Presenting the B read
    WAIT_RSP, // Collecting the B response, A may already be in
    DRAIN,    // Letting the MAC pipeline empty
    STORE,    // Writing the C element
    DONE      // One-cycle end marker
  } engine_state_e;

endpackage

// File: logic/matmul_regs.sv
// Host register block of the matmul tile; holds bases and dimensions, raises start, keeps done
module matmul_regs (
  input  logic                        clk,
  input  logic                        arst_n_i,
  // Host port, always ready
  input  logic                        cfg_we_i,
  input  matmul_tile_pkg::reg_addr_t  cfg_addr_i,
  input  matmul_tile_pkg::data_t      cfg_wdata_i,
  output matmul_tile_pkg::data_t      cfg_rdata_o,
  // Engine side
  input  logic                        busy_i,
  input  logic                        done_i,
  output logic                        start_o,
  output matmul_tile_pkg::addr_t      a_base_o,
  output matmul_tile_pkg::addr_t      b_base_o,
  output matmul_tile_pkg::addr_t      c_base_o,
  output matmul_tile_pkg::dim_t       dim_m_o,
  output matmul_tile_pkg::dim_t       dim_n_o,
  output matmul_tile_pkg::dim_t       dim_k_o
);
  import matmul_tile_pkg::*;

  addr_t a_base_q, b_base_q, c_base_q;
  dim_t  dim_m_q, dim_n_q, dim_k_q;
  logic  start_q;  // Registered start, one cycle after the CTRL write
  logic  done_q;   // Sticky done flag
  logic  start_wr;
  data_t status;

  // Start only from idle; a pending pulse also blocks a second one
  assign start_wr = cfg_we_i && (cfg_addr_i == REG_CTRL) &&
                    cfg_wdata_i[CTRL_START_BIT] && !busy_i && !start_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_base_q <= '0;
      b_base_q <= '0;
      c_base_q <= '0;
      dim_m_q  <= '0;
      dim_n_q  <= '0;
      dim_k_q  <= '0;
      start_q  <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      start_q <= start_wr;
      if (cfg_we_i) begin
        case (cfg_addr_i)
          REG_A_BASE: a_base_q <= cfg_wdata_i;
          REG_B_BASE: b_base_q <= cfg_wdata_i;
          REG_C_BASE: c_base_q <= cfg_wdata_i;
          REG_DIMS: begin
            dim_m_q <= cfg_wdata_i[7:0];
            dim_n_q <= cfg_wdata_i[15:8];
            dim_k_q <= cfg_wdata_i[23:16];
          end
          default: ;  // CTRL handled above, STATUS below
        endcase
      end
      // New done event beats a simultaneous clear
      if (done_i) begin
        done_q <= 1'b1;
      end else if (cfg_we_i && (cfg_addr_i == REG_STATUS)) begin
        done_q <= 1'b0;
      end
    end
  end

  always_comb begin
    status                  = '0;
    status[STATUS_BUSY_BIT] = busy_i;  // Live engine level
    status[STATUS_DONE_BIT] = done_q;
  end

  // Read mux, CTRL and unused offsets return zero
  always_comb begin
    case (cfg_addr_i)
      REG_STATUS: cfg_rdata_o = status;
      REG_A_BASE: cfg_rdata_o = a_base_q;
      REG_B_BASE: cfg_rdata_o = b_base_q;
      REG_C_BASE: cfg_rdata_o = c_base_q;
      REG_DIMS:   cfg_rdata_o = {8'h00, dim_k_q, dim_n_q, dim_m_q};
      default:    cfg_rdata_o = '0;
    endcase
  end

  assign start_o  = start_q;
  assign a_base_o = a_base_q;
  assign b_base_o = b_base_q;
  assign c_base_o = c_base_q;
  assign dim_m_o  = dim_m_q;
  assign dim_n_o  = dim_n_q;
  assign dim_k_o  = dim_k_q;

endmodule

// File: matmul_engine/matmul_mac.sv
// Two-stage signed multiply-accumulate used by the matmul engine, cleared between C elements
module matmul_mac (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   clear_i,  // Zero accumulator, flush stage one
  input  logic                   valid_i,
  input  matmul_tile_pkg::elem_t a_i,
  input  matmul_tile_pkg::elem_t b_i,
  output matmul_tile_pkg::acc_t  acc_o
);
  import matmul_tile_pkg::*;

  acc_t prod_q;      // Stage one product
  logic prod_vld_q;
  acc_t acc_q;       // Stage two sum, wraps mod 2^32

  // Stage one valid, dropped by clear
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prod_vld_q <= 1'b0;
    end else begin
      prod_vld_q <= valid_i && !clear_i;
    end
  end

  // Both operands signed, so the 32-bit product is exact
  always_ff @(posedge clk) begin
    if (valid_i) begin
      prod_q <= a_i * b_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;  // In-flight product lost with it
    end else if (prod_vld_q) begin
      acc_q <= acc_q + prod_q;
    end
  end

  assign acc_o = acc_q;

endmodule

// File: matmul_engine/matmul_engine.sv
// Matmul sequencer; walks C in row-major order, feeds A/B pairs to the MAC and writes C back
module matmul_engine (
  input  logic                    clk,
  input  logic                    arst_n_i,
  // From register block
  input  logic                    start_i,
  input  matmul_tile_pkg::addr_t  a_base_i,
  input  matmul_tile_pkg::addr_t  b_base_i,
  input  matmul_tile_pkg::addr_t  c_base_i,
  input  matmul_tile_pkg::dim_t   dim_m_i,
  input  matmul_tile_pkg::dim_t   dim_n_i,
  input  matmul_tile_pkg::dim_t   dim_k_i,
  output logic                    busy_o,
  output logic                    done_o,
  // Memory request, valid/ready
  output logic                    req_valid_o,
  input  logic                    req_ready_i,
  output logic                    req_we_o,
  output matmul_tile_pkg::addr_t  req_addr_o,
  output matmul_tile_pkg::data_t  req_wdata_o,
  // Read responses, in order
  input  logic                    rsp_valid_i,
  input  matmul_tile_pkg::data_t  rsp_rdata_i,
  // MAC
  output logic                    mac_clear_o,
  output logic                    mac_valid_o,
  output matmul_tile_pkg::elem_t  mac_a_o,
  output matmul_tile_pkg::elem_t  mac_b_o,
  input  matmul_tile_pkg::acc_t   mac_acc_i
);
  import matmul_tile_pkg::*;

  engine_state_e state_q;

  dim_t  dim_m_q, dim_n_q, dim_k_q; // Latched at start
  dim_t  i_q, j_q, k_q;             // Row, column, inner index
  addr_t b_base_q;
  addr_t a_row_q;   // a_base + i*K
  addr_t a_addr_q;  // a_row + k
  addr_t b_col_q;   // b_base + j
  addr_t b_addr_q;  // b_col + k*N
  addr_t c_addr_q;  // c_base + i*N + j, just counts up

  logic  req_valid_q, req_we_q;
  addr_t req_addr_q;
  data_t req_wdata_q;

  logic  a_got_q;   // A response in, B still due
  elem_t a_elem_q;
  logic [1:0] drain_cnt_q;

  logic zero_dim, last_i, last_j, last_k, pair_done;

  assign zero_dim  = (dim_m_i == 8'd0) || (dim_n_i == 8'd0) || (dim_k_i == 8'd0);
  assign last_i    = (i_q == dim_m_q - 8'd1);
  assign last_j    = (j_q == dim_n_q - 8'd1);
  assign last_k    = (k_q == dim_k_q - 8'd1);
  assign pair_done = (state_q == WAIT_RSP) && rsp_valid_i && a_got_q; // B arriving

  // Responses come A then B, so a toggle tells them apart
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_got_q <= 1'b0;
    end else if (rsp_valid_i) begin
      a_got_q <= !a_got_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid_i && !a_got_q) begin
      a_elem_q <= elem_t'(rsp_rdata_i[15:0]); // Element in the low half
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      {dim_m_q, dim_n_q, dim_k_q} <= '0;
      {i_q, j_q, k_q}             <= '0;
      b_base_q    <= '0;
      a_row_q     <= '0;
      a_addr_q    <= '0;
      b_col_q     <= '0;
      b_addr_q    <= '0;
      c_addr_q    <= '0;
      req_valid_q <= 1'b0;
      req_we_q    <= 1'b0;
      req_addr_q  <= '0;
      req_wdata_q <= '0;
      drain_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE: if (start_i) begin
          dim_m_q  <= dim_m_i;
          dim_n_q  <= dim_n_i;
          dim_k_q  <= dim_k_i;
          b_base_q <= b_base_i;
          a_row_q  <= a_base_i;
          a_addr_q <= a_base_i;
          b_col_q  <= b_base_i;
          b_addr_q <= b_base_i;
          c_addr_q <= c_base_i;
          {i_q, j_q, k_q} <= '0;
          state_q  <= zero_dim ? DONE : ISSUE_A; // Nothing to fetch on a zero dim
        end
        ISSUE_A: begin
          if (!req_valid_q) begin
            req_valid_q <= 1'b1;  // Present A one cycle after entry
            req_we_q    <= 1'b0;
            req_addr_q  <= a_addr_q;
          end else if (req_ready_i) begin
            req_addr_q <= b_addr_q; // B goes out right behind A
            state_q    <= ISSUE_B;
          end
        end
        ISSUE_B: if (req_ready_i) begin
          req_valid_q <= 1'b0;
          state_q     <= WAIT_RSP;
        end
        WAIT_RSP: if (pair_done) begin
          if (last_k) begin
            drain_cnt_q <= '0;
            state_q     <= DRAIN;
          end else begin
            k_q      <= k_q + 8'd1;
            a_addr_q <= a_addr_q + 32'd1;            // Next column of A
            b_addr_q <= b_addr_q + addr_t'(dim_n_q); // Next row of B
            state_q  <= ISSUE_A;
          end
        end
        DRAIN: begin
          drain_cnt_q <= drain_cnt_q + 2'd1;
          if (drain_cnt_q == 2'(MAC_LAT - 1)) begin
            req_valid_q <= 1'b1;  // Accumulator final from here
            req_we_q    <= 1'b1;
            req_addr_q  <= c_addr_q;
            req_wdata_q <= data_t'(mac_acc_i);
            state_q     <= STORE;
          end
        end
        STORE: if (req_ready_i) begin
          req_valid_q <= 1'b0;
          req_we_q    <= 1'b0;
          c_addr_q    <= c_addr_q + 32'd1;
          k_q         <= '0;
          if (last_j) begin
            j_q      <= '0;  // Wrap to next row
            i_q      <= i_q + 8'd1;
            a_row_q  <= a_row_q + addr_t'(dim_k_q);
            a_addr_q <= a_row_q + addr_t'(dim_k_q);
            b_col_q  <= b_base_q;
            b_addr_q <= b_base_q;
          end else begin
            j_q      <= j_q + 8'd1;
            a_addr_q <= a_row_q;  // Same A row again
            b_col_q  <= b_col_q + 32'd1;
            b_addr_q <= b_col_q + 32'd1;
          end
          state_q <= (last_i && last_j) ? DONE : ISSUE_A;
        end
        DONE:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  assign busy_o      = (state_q != IDLE);
  assign done_o      = (state_q == DONE);  // Drops with busy
  assign req_valid_o = req_valid_q;
  assign req_we_o    = req_we_q;
  assign req_addr_o  = req_addr_q;
  assign req_wdata_o = req_wdata_q;

  // Fresh accumulator at start and once each C word is accepted
  assign mac_clear_o = ((state_q == IDLE) && start_i) || ((state_q == STORE) && req_ready_i);
  assign mac_valid_o = pair_done;
  assign mac_a_o     = a_elem_q;
  assign mac_b_o     = elem_t'(rsp_rdata_i[15:0]); // B straight from the response

endmodule

// File: logic/matmul_tile.sv
// Matmul tile top level; host register port plus one memory port, instantiate in the system
module matmul_tile (
  input  logic                       clk,
  input  logic                       arst_n_i,
  // Host register port
  input  logic                       cfg_we_i,
  input  matmul_tile_pkg::reg_addr_t cfg_addr_i,
  input  matmul_tile_pkg::data_t     cfg_wdata_i,
  output matmul_tile_pkg::data_t     cfg_rdata_o,
  // Memory request port
  output logic                       req_valid_o,
  input  logic                       req_ready_i,
  output logic                       req_we_o,
  output matmul_tile_pkg::addr_t     req_addr_o,
  output matmul_tile_pkg::data_t     req_wdata_o,
  // Memory response port
  input  logic                       rsp_valid_i,
  input  matmul_tile_pkg::data_t     rsp_rdata_i,
  // Status
  output logic                       busy_o,
  output logic                       done_irq_o
);
  import matmul_tile_pkg::*;

  logic  start, busy, done;
  addr_t a_base, b_base, c_base;
  dim_t  dim_m, dim_n, dim_k;
  logic  mac_clear, mac_valid;
  elem_t mac_a, mac_b;
  acc_t  acc;

  matmul_regs matmul_regs_i (
    .clk         ( clk         ),
    .arst_n_i    ( arst_n_i    ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .busy_i      ( busy        ),
    .done_i      ( done        ),
    .start_o     ( start       ),
    .a_base_o    ( a_base      ),
    .b_base_o    ( b_base      ),
    .c_base_o    ( c_base      ),
    .dim_m_o     ( dim_m       ),
    .dim_n_o     ( dim_n       ),
    .dim_k_o     ( dim_k       )
  );

  matmul_engine matmul_engine_i (
    .clk         ( clk         ),
    .arst_n_i    ( arst_n_i    ),
    .start_i     ( start       ),
    .a_base_i    ( a_base      ),
    .b_base_i    ( b_base      ),
    .c_base_i    ( c_base      ),
    .dim_m_i     ( dim_m       ),
    .dim_n_i     ( dim_n       ),
    .dim_k_i     ( dim_k       ),
    .busy_o      ( busy        ),
    .done_o      ( done        ),
    .req_valid_o ( req_valid_o ),
    .req_ready_i ( req_ready_i ),
    .req_we_o    ( req_we_o    ),
    .req_addr_o  ( req_addr_o  ),
    .req_wdata_o ( req_wdata_o ),
    .rsp_valid_i ( rsp_valid_i ),
    .rsp_rdata_i ( rsp_rdata_i ),
    .mac_clear_o ( mac_clear   ),
    .mac_valid_o ( mac_valid   ),
    .mac_a_o     ( mac_a       ),
    .mac_b_o     ( mac_b       ),
    .mac_acc_i   ( acc         )
  );

  matmul_mac matmul_mac_i (
    .clk      ( clk       ),
    .arst_n_i ( arst_n_i  ),
    .clear_i  ( mac_clear ),
    .valid_i  ( mac_valid ),
    .a_i      ( mac_a     ),
    .b_i      ( mac_b     ),
    .acc_o    ( acc       )
  );

  assign busy_o     = busy;
  assign done_irq_o = done;  // Engine done is already a single-cycle pulse

endmodule

// File: verif/matmul_tile_mem.sv
// Simulated word memory for the matmul tile testbench; preloaded by hierarchy, random ready stalls
module matmul_tile_mem #(
  parameter int unsigned WORDS     = 4096,
  parameter int unsigned STALL_PCT = 25    // Chance in percent that ready drops for a cycle
) (
  input  logic                   clk,
  input  logic                   arst_n_i,
  // Request side, valid/ready
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   req_we_i,
  input  matmul_tile_pkg::addr_t req_addr_i,
  input  matmul_tile_pkg::data_t req_wdata_i,
  // Read responses, in order
  output logic                   rsp_valid_o,
  output matmul_tile_pkg::data_t rsp_rdata_o
);
  import matmul_tile_pkg::*;

  localparam int unsigned AW = $clog2(WORDS);

  data_t         mem [WORDS];     // Filled by the testbench before each run
  integer        seed     = 32'h7a7a;
  int unsigned   wr_cnt   = 0;    // Accepted writes
  int unsigned   rd_cnt   = 0;    // Accepted reads
  int unsigned   addr_err = 0;    // Requests beyond the last word
  logic          accept;
  logic [AW-1:0] idx;

  assign accept = req_valid_i && req_ready_o;
  assign idx    = req_addr_i[AW-1:0];

  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_rdata_o <= '0;
    end else begin
      // Ready for the coming cycle, independent of valid
      req_ready_o <= ($unsigned($random(seed)) % 100) >= STALL_PCT;
      rsp_valid_o <= accept && !req_we_i;  // One cycle after acceptance
      if (accept && (req_addr_i >= WORDS))
        addr_err++;
      if (accept && !req_we_i) begin
        rsp_rdata_o <= mem[idx];
        rd_cnt++;
      end
      if (accept && req_we_i) begin
        mem[idx] = req_wdata_i;  // Same array the testbench preloads
        wr_cnt++;
      end
    end
  end

endmodule

// File: verif/matmul_tile_tb.sv
// Directed testbench of the matmul tile; programs the host port, runs the engine and checks C
module matmul_tile_tb;
  import matmul_tile_pkg::*;

  localparam int unsigned CLK_PERIOD = 100;
  localparam int unsigned MEM_WORDS  = 4096;
  localparam int unsigned STALL_PCT  = 25;
  localparam int unsigned RAND_RUNS  = 6;
  localparam int unsigned PER_K      = 8;  // Two issues, two responses, stall slack
  localparam addr_t       A_BASE     = 32'h100;
  localparam addr_t       B_BASE     = 32'h200;
  localparam addr_t       C_BASE     = 32'h300;

  // Named after the DUT ports
  logic        clk = 1'b0;
  logic        arst_n_i;
  logic        cfg_we_i;
  reg_addr_t   cfg_addr_i;
  data_t       cfg_wdata_i;
  data_t       cfg_rdata_o;
  logic        req_valid_o;
  logic        req_ready_i;
  logic        req_we_o;
  addr_t       req_addr_o;
  data_t       req_wdata_o;
  logic        rsp_valid_i;
  data_t       rsp_rdata_i;
  logic        busy_o;
  logic        done_irq_o;
  integer      seed     = 32'h7a7a;
  int unsigned done_cnt = 0;  // done_irq_o pulses so far

  matmul_tile matmul_tile_i (.*);

  matmul_tile_mem #(.WORDS(MEM_WORDS), .STALL_PCT(STALL_PCT)) matmul_tile_mem_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_o),
    .req_ready_o (req_ready_i),
    .req_we_i    (req_we_o),
    .req_addr_i  (req_addr_o),
    .req_wdata_i (req_wdata_o),
    .rsp_valid_o (rsp_valid_i),
    .rsp_rdata_o (rsp_rdata_i)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(negedge clk) begin
    if (done_irq_o)
      done_cnt <= done_cnt + 1;
  end

  // Worst case per run, MAC_LAT drain plus store and turnaround per C word
  function automatic int unsigned run_bound(int unsigned m, int unsigned n, int unsigned k);
    return m * n * (k * PER_K + MAC_LAT + 4) + 10;
  endfunction

  function automatic data_t fill_word(addr_t a);
    return 32'hA5A5_0000 ^ (a * 32'h0001_0001);  // Whole address in both halves
  endfunction

  // C[i][j] from the A and B words now in memory, wraps mod 2^32
  function automatic data_t ref_elem(int unsigned n, int unsigned k, int unsigned i,
                                     int unsigned j);
    int      acc;
    shortint a;
    shortint b;
    acc = 0;
    for (int unsigned x = 0; x < k; x++) begin
      a = shortint'(matmul_tile_mem_i.mem[A_BASE + i * k + x][15:0]);
      b = shortint'(matmul_tile_mem_i.mem[B_BASE + x * n + j][15:0]);
      acc += int'(a) * int'(b);
    end
    return data_t'(acc);
  endfunction

  initial begin
    int unsigned limit;
    limit = 4 * (RAND_RUNS * run_bound(6, 6, 6) + run_bound(2, 2, 3) + run_bound(3, 3, 3) +
                 4 * run_bound(0, 0, 0) + 200);
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles", limit);
    $display("Test failed");
    $fatal(1, "Simulation timed out");
  end

  task automatic check_eq(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("ERROR: %s is 0x%08h, expected 0x%08h", name, got, exp);
      $display("Test failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Run aborted");
  endtask

  task automatic preload(input addr_t addr, input data_t data);
    matmul_tile_mem_i.mem[addr] = data;
  endtask

  task automatic cfg_write(input reg_addr_t addr, input data_t data);
    @(negedge clk);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(negedge clk);  // Taken at the rising edge in between
    cfg_we_i = 1'b0;
  endtask

  task automatic cfg_read(input reg_addr_t addr, output data_t data);
    @(negedge clk);
    cfg_addr_i = addr;
    #(CLK_PERIOD / 4);  // Read mux settled, well before the next edge
    data = cfg_rdata_o;
  endtask

  task automatic configure(input int unsigned m, input int unsigned n, input int unsigned k);
    cfg_write(REG_A_BASE, A_BASE);
    cfg_write(REG_B_BASE, B_BASE);
    cfg_write(REG_C_BASE, C_BASE);
    cfg_write(REG_DIMS, {8'h00, 8'(k), 8'(n), 8'(m)});
  endtask

  // Random words, upper half is junk the engine must ignore
  task automatic load_block(input addr_t base, input int unsigned count, input bit extreme);
    data_t w;
    for (int unsigned x = 0; x < count; x++) begin
      w = $random(seed);
      if (extreme)
        w[15:0] = 16'h8000;
      preload(base + x, w);
    end
  endtask

  task automatic wait_done(input int unsigned limit);
    int unsigned cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > limit)
        abort_run("Engine did not raise done in time");
    end while (!done_irq_o);
    @(negedge clk);
    check_eq("busy_o", busy_o, 0);  // Falls with done
  endtask

  task automatic run_and_wait(input int unsigned m, input int unsigned n, input int unsigned k);
    cfg_write(REG_CTRL, 32'h1);
    wait_done(4 * run_bound(m, n, k));
  endtask

  task automatic check_matrix(input int unsigned m, input int unsigned n, input int unsigned k);
    for (int unsigned i = 0; i < m; i++)
      for (int unsigned j = 0; j < n; j++)
        check_eq($sformatf("C[%0d][%0d]", i, j), matmul_tile_mem_i.mem[C_BASE + i * n + j],
                 ref_elem(n, k, i, j));
  endtask

  task automatic test_reset_state();
    data_t rd;
    check_eq("busy_o", busy_o, 0);
    check_eq("done_irq_o", done_irq_o, 0);
    check_eq("req_valid_o", req_valid_o, 0);
    cfg_read(REG_STATUS, rd);
    check_eq("STATUS", rd, 0);
  endtask

  task automatic test_reg_readback();
    data_t rd;
    cfg_write(REG_A_BASE, 32'h1234_5678);
    cfg_write(REG_B_BASE, 32'hCAFE_0042);
    cfg_write(REG_C_BASE, 32'h0000_0FFF);
    cfg_write(REG_DIMS, 32'hFF03_0201);  // Top byte is not stored
    cfg_read(REG_A_BASE, rd);
    check_eq("A_BASE", rd, 32'h1234_5678);
    cfg_read(REG_B_BASE, rd);
    check_eq("B_BASE", rd, 32'hCAFE_0042);
    cfg_read(REG_C_BASE, rd);
    check_eq("C_BASE", rd, 32'h0000_0FFF);
    cfg_read(REG_DIMS, rd);
    check_eq("DIMS", rd, 32'h0003_0201);
    cfg_write(REG_DIMS, 32'h0);  // Zero dims, done without memory traffic
    run_and_wait(0, 0, 0);
    cfg_read(REG_STATUS, rd);
    check_eq("STATUS", rd, 32'h2);
    cfg_write(REG_STATUS, 32'h0);
    cfg_read(REG_STATUS, rd);
    check_eq("STATUS", rd, 32'h0);
  endtask

  task automatic test_zero_dims();
    for (int c = 0; c < 3; c++) begin
      configure(c == 0 ? 0 : 2, c == 1 ? 0 : 2, c == 2 ? 0 : 2);
      run_and_wait(0, 0, 0);
      check_eq("memory writes", matmul_tile_mem_i.wr_cnt, 0);
      check_eq("memory reads", matmul_tile_mem_i.rd_cnt, 0);
    end
  endtask

  task automatic test_small_product();
    shortint a_vals [6];
    shortint b_vals [6];
    a_vals = '{3, -2, 7, -5, 0, 4};   // 2x3
    b_vals = '{-1, 6, 2, -8, -3, 5};  // 3x2
    for (int x = 0; x < 6; x++) begin
      preload(A_BASE + x, {16'hBEEF, 16'(a_vals[x])});
      preload(B_BASE + x, {16'hBEEF, 16'(b_vals[x])});
    end
    configure(2, 2, 3);
    run_and_wait(2, 2, 3);
    check_matrix(2, 2, 3);
    check_eq("C[0][0]", matmul_tile_mem_i.mem[C_BASE], 32'hFFFF_FFE4);  // -28 by hand
    check_eq("word below C", matmul_tile_mem_i.mem[C_BASE - 1], fill_word(C_BASE - 1));
    for (int x = 4; x < 8; x++)
      check_eq($sformatf("word C+%0d", x), matmul_tile_mem_i.mem[C_BASE + x],
               fill_word(C_BASE + x));
  endtask

  task automatic test_random_dims();
    int unsigned m;
    int unsigned n;
    int unsigned k;
    for (int r = 0; r < RAND_RUNS; r++) begin
      m = 1 + ($unsigned($random(seed)) % 6);
      n = 1 + ($unsigned($random(seed)) % 6);
      k = 1 + ($unsigned($random(seed)) % 6);
      if (r == 0) begin
        m = 2;
        n = 2;
        k = 6;  // Six products of 2^30 each, sum wraps
      end
      load_block(A_BASE, m * k, r == 0);
      load_block(B_BASE, k * n, r == 0);
      configure(m, n, k);
      run_and_wait(m, n, k);
      check_matrix(m, n, k);
      if (r == 0)
        check_eq("C[0][0] wrapped", matmul_tile_mem_i.mem[C_BASE], 32'h8000_0000);
    end
  endtask

  task automatic test_start_while_busy();
    int unsigned cnt0;
    int unsigned cycles;
    load_block(A_BASE, 9, 1'b0);
    load_block(B_BASE, 9, 1'b0);
    for (int x = 0; x < 9; x++)
      preload(C_BASE + x, fill_word(C_BASE + x));
    configure(3, 3, 3);
    cnt0   = done_cnt;
    cycles = 0;
    cfg_write(REG_CTRL, 32'h1);
    while (!busy_o) begin
      @(negedge clk);
      cycles++;
      if (cycles > 4)
        abort_run("Engine did not go busy after start");
    end
    cfg_write(REG_CTRL, 32'h1);  // Ignored while busy
    wait_done(4 * run_bound(3, 3, 3));
    repeat (20) @(negedge clk);
    check_eq("done_irq_o pulses", done_cnt - cnt0, 1);
    check_eq("busy_o", busy_o, 0);
    check_matrix(3, 3, 3);
  endtask

  initial begin
    arst_n_i    = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = REG_CTRL;
    cfg_wdata_i = '0;
    for (int unsigned a = 0; a < MEM_WORDS; a++)
      preload(a, fill_word(a));
    repeat (2) @(negedge clk);
    arst_n_i = 1'b1;
    test_reset_state();
    test_reg_readback();
    test_zero_dims();
    test_small_product();
    test_random_dims();
    test_start_while_busy();
    check_eq("address errors", matmul_tile_mem_i.addr_err, 0);
    $display("Test passed");
    $finish;
  end

endmodule

// File: matmul_tile.f
common/matmul_tile_pkg.sv
logic/matmul_regs.sv
matmul_engine/matmul_mac.sv
matmul_engine/matmul_engine.sv
logic/matmul_tile.sv
verif/matmul_tile_mem.sv
verif/matmul_tile_tb.sv

// File: Makefile
# Verilator build, run, lint and clean for the matmul tile

VERILATOR ?= verilator
TOP       ?= matmul_tile_tb
FLIST     ?= matmul_tile.f
VFLAGS    ?= -Wno-fatal
OBJ_DIR   ?= obj_dir

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Pass only if the simulation prints the pass message
run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "Test passed"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
